// File: lsu_vectors.txt
# inst rs1_val rs2_val exp0 exp1 (hex)
# store: exp0/exp1 = memory words A and A+1, load: exp0 = rd value, exp1 unused
0020a023 00000100 11223344 11223344 ffbe0041
0000a183 00000100 00000000 11223344 00000000
0020a023 00000111 aabbccdd bbccdd44 ffba00aa
0020a023 00000122 01020304 03040048 ffb60102
0020a023 00000133 55667788 88b3004c ff556677
00209023 00000143 0000beef efaf0050 ffae00be
00209023 00000151 1234cafe ffcafe54 ffaa0055
0020a223 0000015c deadbeef deadbeef ffa60059
00008183 00000110 00000000 00000044 00000000
00008183 00000111 00000000 ffffffdd 00000000
00008183 00000112 00000000 ffffffcc 00000000
00008183 00000113 00000000 ffffffbb 00000000
0000c183 00000111 00000000 000000dd 00000000
0000c183 00000113 00000000 000000bb 00000000
00009183 00000110 00000000 ffffdd44 00000000
00009183 00000111 00000000 ffffccdd 00000000
00009183 00000112 00000000 ffffbbcc 00000000
00009183 00000113 00000000 ffffaabb 00000000
0000d183 00000112 00000000 0000bbcc 00000000
0000d183 00000113 00000000 0000aabb 00000000
0000a183 00000111 00000000 aabbccdd 00000000
ffc0a183 00000126 00000000 01020304 00000000
0000a183 00000133 00000000 55667788 00000000
00008193 00000100 00000000 00000000 00000000

// File: lsu.f
lsu_pkg.sv
lsu_access_if.sv
lsu_decode.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_control.sv
lsu_top.sv
lsu_sva.sv
tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_lsu
FILELIST  ?= lsu.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb_lsu.sv
//////////////////////////////////////////////////////////////////////
// LSU testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_lsu;

    localparam int XLEN   = lsu_pkg::XLEN;
    localparam int STRB_W = lsu_pkg::STRB_W;
    localparam int ADDR_W = 16;

    logic                          aclk;
    logic                          aresetn;
    logic                          inst_en;
    logic [XLEN-1:0]               inst;
    logic                          ready;
    logic [lsu_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [lsu_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [lsu_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]               rs1_val;
    logic [XLEN-1:0]               rs2_val;
    logic                          rd_wr;
    logic [XLEN-1:0]               rd_val;
    logic [STRB_W-1:0]             rd_strb;
    logic                          mem_en;
    logic                          mem_wr;
    logic [ADDR_W-1:0]             mem_addr;
    logic [XLEN-1:0]               mem_wdata;
    logic [STRB_W-1:0]             mem_strb;
    logic [XLEN-1:0]               mem_rdata;
    logic                          mem_ready;

    // Memory and register models
    logic [XLEN-1:0]   mem [0:(1<<ADDR_W)-1];
    logic [XLEN-1:0]   regm;
    logic [XLEN-1:0]   last_val;
    logic [STRB_W-1:0] written;

    // Access in flight as the testbench decodes it
    logic [ADDR_W-1:0] cur_word;
    logic [1:0]        cur_off;
    logic [2:0]        cur_f3;
    logic [4:0]        cur_rd;
    logic              cur_st;
    int                phase_cnt;

    logic [XLEN-1:0] v_inst[$];
    logic [XLEN-1:0] v_rs1[$];
    logic [XLEN-1:0] v_rs2[$];
    logic [XLEN-1:0] v_e0[$];
    logic [XLEN-1:0] v_e1[$];

    int     errors;
    int     cycles;
    int     limit;
    int     stall;
    integer seed;

    lsu_top #(.ADDR_W(ADDR_W)) lsu_top_inst (.*);

    assign mem_rdata = mem[mem_addr];

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_strb(input string name, input logic [STRB_W-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Lanes of rd that one load phase fills
    function automatic logic [STRB_W-1:0] rd_lanes(input logic [2:0] f3, input logic [1:0] off,
                                                   input int phase);
        logic [STRB_W-1:0] m;
        m = '0;
        if (f3[1:0] == 2'b00) begin
            m = 4'b0001;
        end else if (f3[1:0] == 2'b01) begin
            m = (off == 2'd3) ? ((phase == 0) ? 4'b0001 : 4'b0010) : 4'b0011;
        end else begin
            // First phase takes the low 4-off lanes
            for (int i = 0; i < STRB_W; i++) begin
                if ((i < STRB_W - int'(off)) == (phase == 0)) m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory side model and watchdog
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end else if (aresetn && mem_en && mem_ready) begin
            // Phase completion, address and direction of this phase
            check_word("mem_addr", XLEN'(mem_addr), XLEN'(cur_word) + phase_cnt);
            check_bit("mem_wr", mem_wr, cur_st);
            if (mem_wr) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (mem_strb[i]) mem[mem_addr][8*i+:8] = mem_wdata[8*i+:8];
                end
            end
            if (rd_wr) begin
                check_word("rd_addr", XLEN'(rd_addr), XLEN'(cur_rd));
                check_strb("rd_strb", rd_strb, rd_lanes(cur_f3, cur_off, phase_cnt));
                for (int i = 0; i < STRB_W; i++) begin
                    if (rd_strb[i]) regm[8*i+:8] = rd_val[8*i+:8];
                end
                written  = written | rd_strb;
                last_val = rd_val;
            end
            phase_cnt++;
        end
    end

    // Ready after a random 0 to 3 cycle stall
    always @(posedge aclk) begin
        #1;
        if (mem_ready) begin
            mem_ready = 1'b0;
            stall     = $unsigned($random(seed)) % 4;
        end else if (mem_en) begin
            if (stall == 0) mem_ready = 1'b1;
            else stall--;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic read_vectors();
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] f [5];
        fd = $fopen("lsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file lsu_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                // Comment and blank lines give no full match
                if (line.len() > 0 && line[0] != 8'h23 && n == 5) begin
                    v_inst.push_back(f[0]);
                    v_rs1.push_back(f[1]);
                    v_rs2.push_back(f[2]);
                    v_e0.push_back(f[3]);
                    v_e1.push_back(f[4]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_one(input logic [XLEN-1:0] ins, r1, r2, e0, e1);
        logic [11:0]     imm;
        logic [XLEN-1:0] ea;
        logic [XLEN-1:0] res;
        logic            is_ld;
        logic            is_st;
        int              nphase;
        is_ld = (ins[6:0] == lsu_pkg::OPCODE_LOAD);
        is_st = (ins[6:0] == lsu_pkg::OPCODE_STORE);
        imm   = is_st ? {ins[31:25], ins[11:7]} : ins[31:20];
        ea    = r1 + {{(XLEN-12){imm[11]}}, imm};
        cur_word  = ea[ADDR_W+1:2];
        cur_off   = ea[1:0];
        cur_f3    = ins[14:12];
        cur_rd    = ins[11:7];
        cur_st    = is_st;
        phase_cnt = 0;
        regm      = '0;
        written   = '0;
        nphase = ((ins[13:12] == 2'b01 && ea[1:0] == 2'd3) ||
                  (ins[13:12] == 2'b10 && ea[1:0] != 2'd0)) ? 2 : 1;
        while (!ready) begin
            @(posedge aclk);
            #1;
        end
        inst    = ins;
        rs1_val = r1;
        rs2_val = r2;
        inst_en = 1'b1;
        @(posedge aclk);
        #1;
        inst_en = 1'b0;
        // Source indexes come straight from the held instruction word
        check_word("rs1_addr", XLEN'(rs1_addr), XLEN'(ins[19:15]));
        check_word("rs2_addr", XLEN'(rs2_addr), XLEN'(ins[24:20]));
        if (!is_ld && !is_st) begin
            repeat (3) begin
                check_bit("mem_en", mem_en, 1'b0);
                check_bit("ready", ready, 1'b1);
                @(posedge aclk);
                #1;
            end
        end else begin
            while (!ready) begin
                @(posedge aclk);
                #1;
            end
            if (phase_cnt != nphase) begin
                $display("Access %h made %0d memory phases instead of %0d",
                         ins, phase_cnt, nphase);
                errors++;
            end
            if (is_st) begin
                check_word("mem_word0", mem[cur_word], e0);
                check_word("mem_word1", mem[cur_word+1'b1], e1);
            end else begin
                // Unwritten upper lanes carry the extension of the last pulse
                for (int i = 0; i < STRB_W; i++) begin
                    res[8*i+:8] = written[i] ? regm[8*i+:8] : last_val[8*i+:8];
                end
                check_word("rd_reg", res, e0);
            end
        end
    endtask

    initial begin
        seed      = 48;
        errors    = 0;
        cycles    = 0;
        limit     = 0;
        stall     = 0;
        aresetn   = 1'b0;
        inst_en   = 1'b0;
        inst      = '0;
        rs1_val   = '0;
        rs2_val   = '0;
        mem_ready = 1'b0;
        phase_cnt = 0;
        cur_st    = 1'b0;
        // Fill pattern built from the full word address
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = {~a[15:0], a[15:0]};
        end
        read_vectors();
        limit = v_inst.size() * 12 + 50;
        repeat (4) begin
            @(posedge aclk);
            #1;
            check_bit("ready", ready, 1'b0);
            check_bit("mem_en", mem_en, 1'b0);
            check_bit("rd_wr", rd_wr, 1'b0);
        end
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        check_bit("ready", ready, 1'b1);
        for (int i = 0; i < v_inst.size(); i++) begin
            run_one(v_inst[i], v_rs1[i], v_rs2[i], v_e0[i], v_e1[i]);
        end
        $display("Vectors: %0d, errors: %0d", v_inst.size(), errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: lsu_sva.sv
//////////////////////////////////////////////////////////////////////
// Handshake assertions for the LSU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_sva #(
    parameter int ADDR_W = 16
)(
    input logic                         aclk,
    input logic                         aresetn,
    input logic                         ready,
    input logic                         mem_en,
    input logic                         mem_wr,
    input logic                         mem_ready,
    input logic [ADDR_W-1:0]            mem_addr,
    input logic [lsu_pkg::STRB_W-1:0]   mem_strb,
    input logic                         rd_wr
);

    // Request held while the memory stalls
    assert property (@(posedge aclk) disable iff (!aresetn)
        (mem_en && !mem_ready) |=> ($stable(mem_addr) && $stable(mem_wr) && $stable(mem_strb)))
        else $error("memory request changed during a stall");

    // Register write only on a completing load phase
    assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> (mem_en && mem_ready && !mem_wr))
        else $error("rd_wr outside a load phase completion");

    // Busy and idle are exclusive
    assert property (@(posedge aclk) disable iff (!aresetn) !(ready && mem_en))
        else $error("ready and mem_en high together");

endmodule

bind lsu_top lsu_sva #(.ADDR_W(ADDR_W)) lsu_sva_inst (.*);

// File: lsu_top.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_top #(
    parameter int ADDR_W = 16
)(
    input  logic                            aclk,
    input  logic                            aresetn,
    // Instruction side
    input  logic                            inst_en,
    input  logic [lsu_pkg::XLEN-1:0]        inst,
    output logic                            ready,
    // Register file reads
    output logic [lsu_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [lsu_pkg::XLEN-1:0]        rs1_val,
    output logic [lsu_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [lsu_pkg::XLEN-1:0]        rs2_val,
    // Register file write
    output logic                            rd_wr,
    output logic [lsu_pkg::REG_ADDR_W-1:0]  rd_addr,
    output logic [lsu_pkg::XLEN-1:0]        rd_val,
    output logic [lsu_pkg::STRB_W-1:0]      rd_strb,
    // Data memory
    output logic                            mem_en,
    output logic                            mem_wr,
    output logic [ADDR_W-1:0]               mem_addr,
    output logic [lsu_pkg::XLEN-1:0]        mem_wdata,
    output logic [lsu_pkg::STRB_W-1:0]      mem_strb,
    input  logic [lsu_pkg::XLEN-1:0]        mem_rdata,
    input  logic                            mem_ready
);

    logic [2:0] funct3_q;
    logic [1:0] offset_q;
    logic       second_phase;

    // Decoded access shared by decoder, store aligner and sequencer
    lsu_access_if #(.ADDR_W(ADDR_W)) acc_if ();

    lsu_decode #(.ADDR_W(ADDR_W)) lsu_decode_inst (
        .inst     (inst),
        .rs1_val  (rs1_val),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .acc      (acc_if.decoder)
    );

    lsu_store_align lsu_store_align_inst (
        .rs2_val (rs2_val),
        .acc     (acc_if.align)
    );

    lsu_control #(.ADDR_W(ADDR_W)) lsu_control_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .inst_en      (inst_en),
        .ready        (ready),
        .acc          (acc_if.control),
        .mem_en       (mem_en),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_strb     (mem_strb),
        .mem_ready    (mem_ready),
        .rd_wr        (rd_wr),
        .rd_addr      (rd_addr),
        .funct3_q     (funct3_q),
        .offset_q     (offset_q),
        .second_phase (second_phase)
    );

    // Read data path back to rd
    lsu_load_align lsu_load_align_inst (
        .funct3_q     (funct3_q),
        .offset_q     (offset_q),
        .second_phase (second_phase),
        .mem_rdata    (mem_rdata),
        .rd_val       (rd_val),
        .rd_strb      (rd_strb)
    );

endmodule

// File: lsu_control.sv
//////////////////////////////////////////////////////////////////////
// Memory request sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_control #(
    parameter int ADDR_W = 16
)(
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            inst_en,
    output logic                            ready,
    lsu_access_if.control                   acc,
    output logic                            mem_en,
    output logic                            mem_wr,
    output logic [ADDR_W-1:0]               mem_addr,
    output logic [lsu_pkg::XLEN-1:0]        mem_wdata,
    output logic [lsu_pkg::STRB_W-1:0]      mem_strb,
    input  logic                            mem_ready,
    output logic                            rd_wr,
    output logic [lsu_pkg::REG_ADDR_W-1:0]  rd_addr,
    output logic [2:0]                      funct3_q,
    output logic [1:0]                      offset_q,
    output logic                            second_phase
);

    logic                          accept;
    logic                          phase_done;
    logic                          is_load_q;
    logic                          pending_q;
    logic [lsu_pkg::STRB_W-1:0]    strb1_q;

    // Only loads and stores are taken, other opcodes pass by
    assign accept     = ready & inst_en & (acc.is_load | acc.is_store);
    assign phase_done = mem_en & mem_ready;

    //////////////////////////////////////////////////////////////////////
    // Sequencing state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ready        <= 1'b0;
            mem_en       <= 1'b0;
            mem_wr       <= 1'b0;
            is_load_q    <= 1'b0;
            pending_q    <= 1'b0;
            second_phase <= 1'b0;
        end else if (mem_en) begin
            if (mem_ready) begin
                if (pending_q) begin
                    // First half done, request stays up for the next word
                    pending_q    <= 1'b0;
                    second_phase <= 1'b1;
                end else begin
                    mem_en <= 1'b0;
                    mem_wr <= 1'b0;
                    ready  <= 1'b1;
                end
            end
        end else if (accept) begin
            ready        <= 1'b0;
            mem_en       <= 1'b1;
            mem_wr       <= acc.is_store;
            is_load_q    <= acc.is_load;
            pending_q    <= acc.split;
            second_phase <= 1'b0;
        end else begin
            // Idle, open for the next instruction
            ready <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (accept) begin
            mem_addr  <= acc.word_addr;
            mem_wdata <= acc.wdata;
            // Loads leave the strobes clear
            mem_strb  <= acc.is_store ? acc.strb0 : '0;
            strb1_q   <= acc.is_store ? acc.strb1 : '0;
            rd_addr   <= acc.rd;
            funct3_q  <= acc.funct3;
            offset_q  <= acc.offset;
        end else if (phase_done && pending_q) begin
            // Move on to the following word with the spill strobes
            mem_addr <= mem_addr + 1'b1;
            mem_strb <= strb1_q;
        end
    end

    // Register write fires on every load phase completion
    assign rd_wr = phase_done & is_load_q;

endmodule

// File: lsu_load_align.sv
//////////////////////////////////////////////////////////////////////
// Load data alignment and extension
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_load_align (
    input  logic [2:0]                 funct3_q,
    input  logic [1:0]                 offset_q,
    input  logic                       second_phase,
    input  logic [lsu_pkg::XLEN-1:0]   mem_rdata,
    output logic [lsu_pkg::XLEN-1:0]   rd_val,
    output logic [lsu_pkg::STRB_W-1:0] rd_strb
);

    logic [2*lsu_pkg::XLEN-1:0] rdata_dbl;
    logic [lsu_pkg::XLEN-1:0]   rdata_rot;
    logic [lsu_pkg::STRB_W-1:0] low_mask;

    // Rotate right by offset bytes, lower half of the doubled word
    assign rdata_dbl = {mem_rdata, mem_rdata} >> {offset_q, 3'b000};
    assign rdata_rot = rdata_dbl[lsu_pkg::XLEN-1:0];

    // Size and sign handling
    always_comb begin
        case (funct3_q)
            lsu_pkg::F3_B:  rd_val = {{24{rdata_rot[7]}}, rdata_rot[7:0]};
            lsu_pkg::F3_BU: rd_val = {24'd0, rdata_rot[7:0]};
            lsu_pkg::F3_H:  rd_val = {{16{rdata_rot[15]}}, rdata_rot[15:0]};
            lsu_pkg::F3_HU: rd_val = {16'd0, rdata_rot[15:0]};
            default:        rd_val = rdata_rot;
        endcase
    end

    // Word lanes filled by the first phase, 4-offset of them
    assign low_mask = 4'b1111 >> offset_q;

    // Lanes of rd written in this phase
    always_comb begin
        case (funct3_q)
            lsu_pkg::F3_B,
            lsu_pkg::F3_BU: rd_strb = 4'b0001;
            lsu_pkg::F3_H,
            lsu_pkg::F3_HU: begin
                if (offset_q == 2'd3) begin
                    rd_strb = second_phase ? 4'b0010 : 4'b0001;
                end else begin
                    rd_strb = 4'b0011;
                end
            end
            // Second phase of a word fills the remaining top lanes
            default:        rd_strb = second_phase ? ~low_mask : low_mask;
        endcase
    end

endmodule

// File: lsu_store_align.sv
//////////////////////////////////////////////////////////////////////
// Store data and strobe alignment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_store_align (
    input  logic [lsu_pkg::XLEN-1:0] rs2_val,
    lsu_access_if.align              acc
);

    logic [2*lsu_pkg::XLEN-1:0]   wdata_dbl;
    logic [lsu_pkg::STRB_W-1:0]   base_strb;
    logic [2*lsu_pkg::STRB_W-1:0] strb_dbl;

    // Rotate left by offset bytes, upper half of the doubled word
    assign wdata_dbl = {rs2_val, rs2_val} << {acc.offset, 3'b000};
    assign acc.wdata = wdata_dbl[2*lsu_pkg::XLEN-1:lsu_pkg::XLEN];

    // Lanes covered by the access before alignment
    always_comb begin
        case (acc.funct3)
            lsu_pkg::F3_B: base_strb = 4'b0001;
            lsu_pkg::F3_H: base_strb = 4'b0011;
            default:       base_strb = 4'b1111;
        endcase
    end

    // Shift into an eight-lane window
    assign strb_dbl = {{lsu_pkg::STRB_W{1'b0}}, base_strb} << acc.offset;

    // Low half hits the first word, the spill goes to the next one
    assign acc.strb0 = strb_dbl[lsu_pkg::STRB_W-1:0];
    assign acc.strb1 = strb_dbl[2*lsu_pkg::STRB_W-1:lsu_pkg::STRB_W];

endmodule

// File: lsu_decode.sv
//////////////////////////////////////////////////////////////////////
// Load/store decoder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_decode #(
    parameter int ADDR_W = 16
)(
    input  lsu_pkg::inst_u                   inst,
    input  logic [lsu_pkg::XLEN-1:0]         rs1_val,
    output logic [lsu_pkg::REG_ADDR_W-1:0]   rs1_addr,
    output logic [lsu_pkg::REG_ADDR_W-1:0]   rs2_addr,
    lsu_access_if.decoder                    acc
);

    logic [11:0]              imm12;
    logic [lsu_pkg::XLEN-1:0] addr;

    // Register indexes sit at the same bits in both layouts
    assign rs1_addr = inst.i_fmt.rs1;
    assign rs2_addr = inst.s_fmt.rs2;

    assign acc.is_load  = (inst.i_fmt.opcode == lsu_pkg::OPCODE_LOAD);
    assign acc.is_store = (inst.i_fmt.opcode == lsu_pkg::OPCODE_STORE);
    assign acc.funct3   = inst.i_fmt.funct3;
    assign acc.rd       = inst.i_fmt.rd;

    // Stores take the split immediate, everything else the I-type one
    assign imm12 = acc.is_store ? {inst.s_fmt.imm_hi, inst.s_fmt.imm_lo} : inst.i_fmt.imm;

    // Effective byte address
    assign addr = rs1_val + {{(lsu_pkg::XLEN-12){imm12[11]}}, imm12};

    assign acc.word_addr = addr[ADDR_W+1:2];
    assign acc.offset    = addr[1:0];

    // Halfword at the last lane or any misaligned word spills into the next word
    always_comb begin
        case (acc.funct3)
            lsu_pkg::F3_H,
            lsu_pkg::F3_HU: acc.split = (addr[1:0] == 2'd3);
            lsu_pkg::F3_W:  acc.split = (addr[1:0] != 2'd0);
            default:        acc.split = 1'b0;
        endcase
    end

endmodule

// File: lsu_access_if.sv
//////////////////////////////////////////////////////////////////////
// Decoded memory access bundle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface lsu_access_if #(
    parameter int ADDR_W = 16
);
    // Access kind and size
    logic                          is_load;
    logic                          is_store;
    logic [2:0]                    funct3;
    logic [lsu_pkg::REG_ADDR_W-1:0] rd;

    // Location, split into word address and byte offset
    logic [ADDR_W-1:0]             word_addr;
    logic [1:0]                    offset;
    logic                          split;

    // Store payload, lanes already rotated
    logic [lsu_pkg::XLEN-1:0]      wdata;
    logic [lsu_pkg::STRB_W-1:0]    strb0;
    logic [lsu_pkg::STRB_W-1:0]    strb1;

    modport decoder (output is_load, is_store, funct3, rd, word_addr, offset, split);
    modport align   (input funct3, offset, output wdata, strb0, strb1);
    modport control (input is_load, is_store, funct3, rd, word_addr, offset, split,
                     wdata, strb0, strb1);

endinterface

// File: lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit shared definitions
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

    // Data path and register file widths
    localparam int XLEN       = 32;
    localparam int STRB_W     = XLEN / 8;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the unit
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Access size codes, stores only use B, H and W
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // One instruction word, two immediate layouts
    typedef union packed {
        // Loads: contiguous 12-bit immediate
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        // Stores: immediate split around rs2 and rs1
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s_fmt;
    } inst_u;

endpackage
